// File: vlog.f
rtl/rv_isa_pkg.sv
rtl/exec_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/exec_ctrl.sv
rtl/exec_unit_top.sv
tests/exec_unit_props.sv
tests/exec_checker.sv
tests/tb_exec_unit.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_exec_unit
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

// File: tests/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
	import rv_isa_pkg::*;
	import exec_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic        instr_ready;
	issue_t      instr;
	logic        res_valid;
	logic        res_ready;
	result_t     res;
	logic [31:0] rng;
	logic [31:0] pc;
	logic [4:0]  last_rd;
	logic        gaps_on;
	logic        timed_out;
	int          mismatches;
	int          orphans;
	int          pending;

	exec_unit_top u_exec_unit_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res         (res)
	);

	exec_checker u_exec_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.instr       (instr),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res         (res),
		.mismatches  (mismatches),
		.orphans     (orphans),
		.pending     (pending)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng = x;
		return x;
	endfunction

	// Next falling edge, with a fresh draw for the sink's ready
	task automatic step();
		@(negedge clk);
		if (gaps_on)
			res_ready = (xorshift32() % 4) != 0;
		else
			res_ready = 1'b1;
	endtask

	task automatic send(input logic [31:0] iw);
		int   gap;
		int   waited;
		logic taken;
		gap = gaps_on ? int'(xorshift32() % 3) : 0;
		for (int i = 0; i < gap; i++) begin
			instr_valid = 1'b0;
			step();
		end
		instr_valid = 1'b1;
		instr.pc = pc;
		instr.instr.raw = iw;
		taken = 1'b0;
		waited = 0;
		while (!taken && !timed_out) begin
			@(posedge clk);
			taken = instr_ready;
			step();
			waited++;
			if (!taken && waited > 200) begin
				$display("%0t: instruction at pc %h was never accepted", $time, pc);
				timed_out = 1'b1;
			end
		end
		instr_valid = 1'b0;
		pc = pc + 32'd4;
	endtask

	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [31:0] kind;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [6:0]  f7;
		logic [11:0] imm;
		r = xorshift32();
		kind = xorshift32() % 100;
		// Reuse the previous rd often so that hazards come up
		rs1 = (xorshift32() % 3 == 0) ? last_rd : r[19:15];
		rs2 = (xorshift32() % 5 == 0) ? last_rd : r[24:20];
		f7 = (r[30] && (r[14:12] == f3_add || r[14:12] == f3_sr)) ? f7_alt : f7_base;
		if (xorshift32() % 16 == 0)
			f7 = r[31:25];
		imm = r[31:20];
		if (r[14:12] == f3_sll || r[14:12] == f3_sr)
			imm[11:5] = f7;
		if (kind < 5)
			return {r[31:9], 2'b00, r[8] ? 7'b1100011 : 7'b0000011};
		if (kind < 45)
			return {f7, rs2, rs1, r[14:12], r[11:7], op_op};
		if (kind < 85)
			return {imm, rs1, r[14:12], r[11:7], op_op_imm};
		if (kind < 93)
			return {r[31:12], r[11:7], op_lui};
		return {r[31:12], r[11:7], op_auipc};
	endfunction

	initial begin
		logic [31:0] v;
		logic [31:0] iw;
		int          waited;
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		res_ready = 1'b0;
		rng = 32'd5;
		pc = 32'h1000;
		last_rd = 5'd0;
		gaps_on = 1'b0;
		timed_out = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		res_ready = 1'b1;
		// LUI then ADDI on the same register, so each ADDI also waits on a hazard
		for (int i = 1; i < 32 && !timed_out; i++) begin
			v = xorshift32();
			send({v[31:12], 5'(i), op_lui});
			v = xorshift32();
			send({v[11:0], 5'(i), f3_add, 5'(i), op_op_imm});
		end
		for (int n = 0; n < 2000 && !timed_out; n++) begin
			gaps_on = (n >= 600);
			iw = random_instr();
			send(iw);
			last_rd = iw[11:7];
		end
		gaps_on = 1'b0;
		waited = 0;
		while (pending != 0 && !timed_out) begin
			step();
			waited++;
			if (waited > 100) begin
				$display("%0t: results still missing after the last instruction", $time);
				timed_out = 1'b1;
			end
		end
		repeat (4) step();
		$display("errors: mismatches=%0d unexpected=%0d missing=%0d timeout=%0d",
				mismatches, orphans, pending, timed_out);
		if (mismatches == 0 && orphans == 0 && pending == 0 && !timed_out)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: tests/exec_checker.sv
`timescale 1ns/1ps

module exec_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  logic              instr_ready,
	input  exec_pkg::issue_t  instr,
	input  logic              res_valid,
	input  logic              res_ready,
	input  exec_pkg::result_t res,
	output int                mismatches,
	output int                orphans,
	output int                pending
);
	import exec_pkg::*;

	logic [xlen-1:0] model_regs [nregs];
	result_t         expected_q [$];

	// alt picks sub for funct3 0 and the arithmetic shift for funct3 5
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = $signed(a) >>> b[4:0];
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? sa : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Expected result of one accepted instruction, applied to the model registers
	function automatic result_t model_issue(input issue_t it);
		logic [31:0] iw;
		logic [31:0] value;
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic        legal;
		result_t     r;
		iw = it.instr.raw;
		f7 = iw[31:25];
		f3 = iw[14:12];
		legal = 1'b1;
		value = '0;
		case (iw[6:0])
			7'b0110111: value = {iw[31:12], 12'b0};
			7'b0010111: value = it.pc + {iw[31:12], 12'b0};
			7'b0110011: begin
				legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				value = alu_model(f3, f7[5], model_regs[iw[19:15]], model_regs[iw[24:20]]);
			end
			7'b0010011: begin
				// Shift immediates keep a funct7 in imm[11:5]
				if (f3 == 3'd1)
					legal = f7 == 7'h00;
				else if (f3 == 3'd5)
					legal = f7 == 7'h00 || f7 == 7'h20;
				value = alu_model(f3, f3 == 3'd5 && f7[5], model_regs[iw[19:15]],
						{{20{iw[31]}}, iw[31:20]});
			end
			default: legal = 1'b0;
		endcase
		r.pc = it.pc;
		r.rd = legal ? iw[11:7] : 5'd0;
		r.value = legal ? value : 32'd0;
		r.illegal = !legal;
		if (legal && iw[11:7] != 5'd0)
			model_regs[iw[11:7]] = value;
		return r;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("[FAIL] time=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
			mismatches++;
		end
	endtask

	always @(posedge clk) begin
		result_t exp_r;
		if (!rst_n) begin
			for (int i = 0; i < nregs; i++)
				model_regs[i] = '0;
			expected_q.delete();
			mismatches = 0;
			orphans = 0;
		end else begin
			if (res_valid && res_ready) begin
				if (expected_q.size() == 0) begin
					$display("%0t: result for pc %h came with no instruction pending",
							$time, res.pc);
					orphans++;
				end else begin
					exp_r = expected_q.pop_front();
					check_field("res.pc", exp_r.pc, res.pc);
					check_field("res.rd", 32'(exp_r.rd), 32'(res.rd));
					check_field("res.value", exp_r.value, res.value);
					check_field("res.illegal", 32'(exp_r.illegal), 32'(res.illegal));
				end
			end
			if (instr_valid && instr_ready)
				expected_q.push_back(model_issue(instr));
		end
		pending = expected_q.size();
	end

endmodule

// File: tests/exec_unit_props.sv
`timescale 1ns/1ps

module exec_unit_props (
	input logic              clk,
	input logic              rst_n,
	input logic              instr_ready,
	input logic              res_valid,
	input logic              res_ready,
	input exec_pkg::result_t res
);
	// Nothing is offered or accepted while reset holds
	reset_quiet: assert property (@(posedge clk) !rst_n |=> (!res_valid && !instr_ready))
		else $error("res_valid or instr_ready high during reset");

	res_held: assert property (@(posedge clk) disable iff (!rst_n)
			res_valid && !res_ready |=> $stable(res))
		else $error("res changed while the sink was stalling");

	valid_held: assert property (@(posedge clk) disable iff (!rst_n)
			res_valid && !res_ready |=> res_valid)
		else $error("res_valid dropped before the result was taken");

endmodule

bind exec_unit_top exec_unit_props u_exec_unit_props (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_ready (instr_ready),
	.res_valid   (res_valid),
	.res_ready   (res_ready),
	.res         (res)
);

// File: rtl/exec_unit_top.sv
`timescale 1ns/1ps

module exec_unit_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	output logic              instr_ready,
	input  exec_pkg::issue_t  instr,
	output logic              res_valid,
	input  logic              res_ready,
	output exec_pkg::result_t res
);
	import exec_pkg::*;

	typedef struct packed {
		dec_t            dec;
		logic [xlen-1:0] op1;
		logic [xlen-1:0] op2;
		logic [xlen-1:0] pc;
	} d_stage_t;

	dec_t            in_dec;
	d_stage_t        d_q;
	result_t         x_q;
	logic [xlen-1:0] rd1;
	logic [xlen-1:0] rd2;
	logic [xlen-1:0] alu_a;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_y;
	logic            d_load;
	logic            x_load;
	logic            rf_we;

	exec_ctrl u_exec_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.res_ready   (res_ready),
		.res_valid   (res_valid),
		.in_dec      (in_dec),
		.d_dec       (d_q.dec),
		.d_load      (d_load),
		.x_load      (x_load)
	);

	instr_decoder u_instr_decoder (
		.instr (instr.instr),
		.dec   (in_dec)
	);

	// Write happens on the edge the D instruction enters X
	assign rf_we = x_load && d_q.dec.writes_rd && !d_q.dec.illegal;

	reg_file u_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.rs1   (in_dec.rs1),
		.rs2   (in_dec.rs2),
		.rd1   (rd1),
		.rd2   (rd2),
		.we    (rf_we),
		.wa    (d_q.dec.rd),
		.wd    (alu_y)
	);

	assign alu_a = d_q.dec.zero_a ? '0 : (d_q.dec.use_pc ? d_q.pc : d_q.op1);
	assign alu_b = d_q.dec.use_imm ? d_q.dec.imm : d_q.op2;

	alu u_alu (
		.op (d_q.dec.alu_op),
		.a  (alu_a),
		.b  (alu_b),
		.y  (alu_y)
	);

	always_ff @(posedge clk) begin
		if (d_load)
			d_q <= '{dec: in_dec, op1: rd1, op2: rd2, pc: instr.pc};
		if (x_load)
			x_q <= '{pc: d_q.pc, rd: d_q.dec.rd, value: alu_y, illegal: d_q.dec.illegal};
	end

	assign res = x_q;

endmodule

// File: rtl/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           instr_valid,
	output logic           instr_ready,
	input  logic           res_ready,
	output logic           res_valid,
	input  exec_pkg::dec_t in_dec,
	input  exec_pkg::dec_t d_dec,
	output logic           d_load,
	output logic           x_load
);
	logic run;
	logic d_valid;
	logic x_valid;
	logic x_free;
	logic hazard;

	// X can take a new entry when empty or when its result leaves now
	assign x_free = !x_valid || res_ready;

	// The D instruction writes the register file only when it moves to X
	assign hazard = d_valid && d_dec.writes_rd && d_dec.rd != 5'd0 &&
			(in_dec.rs1 == d_dec.rd || in_dec.rs2 == d_dec.rd);

	assign instr_ready = run && (!d_valid || x_free) && !hazard;
	assign d_load = instr_valid && instr_ready;
	assign x_load = run && d_valid && x_free;
	assign res_valid = x_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run <= 1'b0;
			d_valid <= 1'b0;
			x_valid <= 1'b0;
		end else begin
			run <= 1'b1;
			if (d_load)
				d_valid <= 1'b1;
			else if (x_load)
				d_valid <= 1'b0;
			if (x_free)
				x_valid <= d_valid;
		end
	end

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input  exec_pkg::alu_op_e         op,
	input  logic [exec_pkg::xlen-1:0] a,
	input  logic [exec_pkg::xlen-1:0] b,
	output logic [exec_pkg::xlen-1:0] y
);
	import exec_pkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			add:    y = a + b;
			sub:    y = a - b;
			sll:    y = a << shamt;
			slt:    y = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			sltu:   y = {{(xlen-1){1'b0}}, a < b};
			xor_op: y = a ^ b;
			srl:    y = a >> shamt;
			sra:    y = $unsigned($signed(a) >>> shamt);
			or_op:  y = a | b;
			and_op: y = a & b;
			default: y = '0;
		endcase
	end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [4:0]                rs1,
	input  logic [4:0]                rs2,
	output logic [exec_pkg::xlen-1:0] rd1,
	output logic [exec_pkg::xlen-1:0] rd2,
	input  logic                      we,
	input  logic [4:0]                wa,
	input  logic [exec_pkg::xlen-1:0] wd
);
	import exec_pkg::*;

	logic [xlen-1:0] regs [nregs];

	// x0 stays zero because it is cleared on reset and never written
	assign rd1 = regs[rs1];
	assign rd2 = regs[rs2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  rv_isa_pkg::instr_u instr,
	output exec_pkg::dec_t     dec
);
	import rv_isa_pkg::*;
	import exec_pkg::*;

	logic [6:0] opcode;
	logic       bad;

	// Base operation for a funct3, before any funct7 modifier
	function automatic alu_op_e f3_op(input logic [2:0] f3);
		case (f3)
			f3_add:  return add;
			f3_sll:  return sll;
			f3_slt:  return slt;
			f3_sltu: return sltu;
			f3_xor:  return xor_op;
			f3_sr:   return srl;
			f3_or:   return or_op;
			default: return and_op;
		endcase
	endfunction

	assign opcode = instr.raw[6:0];

	always_comb begin
		dec = '0;
		dec.alu_op = add;
		bad = 1'b0;
		case (opcode)
			op_lui, op_auipc: begin
				dec.rd = instr.iu.rd;
				dec.imm = {instr.iu.imm, instr.iu.rs1, instr.iu.funct3, 12'b0};
				dec.use_imm = 1'b1;
				dec.use_pc = (opcode == op_auipc);
				dec.zero_a = (opcode == op_lui);
				dec.writes_rd = 1'b1;
			end
			op_op_imm: begin
				dec.rd = instr.iu.rd;
				dec.rs1 = instr.iu.rs1;
				dec.imm = {{(xlen-12){instr.iu.imm[11]}}, instr.iu.imm};
				dec.use_imm = 1'b1;
				dec.writes_rd = 1'b1;
				dec.alu_op = f3_op(instr.iu.funct3);
				// Shift immediates carry a funct7 in the upper bits
				if (instr.iu.funct3 == f3_sr && instr.iu.imm[11:5] == f7_alt)
					dec.alu_op = sra;
				else if ((instr.iu.funct3 == f3_sll || instr.iu.funct3 == f3_sr) &&
						instr.iu.imm[11:5] != f7_base)
					bad = 1'b1;
			end
			op_op: begin
				dec.rd = instr.r.rd;
				dec.rs1 = instr.r.rs1;
				dec.rs2 = instr.r.rs2;
				dec.writes_rd = 1'b1;
				dec.alu_op = f3_op(instr.r.funct3);
				if (instr.r.funct7 == f7_alt) begin
					if (instr.r.funct3 == f3_add)
						dec.alu_op = sub;
					else if (instr.r.funct3 == f3_sr)
						dec.alu_op = sra;
					else
						bad = 1'b1;
				end else if (instr.r.funct7 != f7_base) begin
					bad = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase
		// Illegal words compute 0 + 0 and write nothing
		if (bad) begin
			dec = '0;
			dec.alu_op = add;
			dec.zero_a = 1'b1;
			dec.use_imm = 1'b1;
			dec.illegal = 1'b1;
		end
	end

endmodule

// File: rtl/exec_pkg.sv
package exec_pkg;

	localparam int xlen  = 32;
	localparam int nregs = 32;

	typedef enum logic [3:0] {
		add,
		sub,
		sll,
		slt,
		sltu,
		xor_op,
		srl,
		sra,
		or_op,
		and_op
	} alu_op_e;

	// Instruction as offered by the source
	typedef struct packed {
		logic [xlen-1:0]    pc;
		rv_isa_pkg::instr_u instr;
	} issue_t;

	typedef struct packed {
		alu_op_e         alu_op;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [xlen-1:0] imm;
		logic            use_imm;
		logic            use_pc;
		logic            zero_a;
		logic            writes_rd;
		logic            illegal;
	} dec_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [4:0]      rd;
		logic [xlen-1:0] value;
		logic            illegal;
	} result_t;

endpackage

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

	// Major opcodes handled by the execute unit
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_op_imm = 7'b0010011;

	// funct3 of the integer ALU group
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// f7_alt turns add into sub and srl into sra
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// Register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	// Immediate layout; for U-type the top 20 bits form the immediate
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} iu_fmt_t;

	typedef union packed {
		r_fmt_t      r;
		iu_fmt_t     iu;
		logic [31:0] raw;
	} instr_u;

endpackage
